// File: la32_pkg.sv
package la32_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam logic [DATA_WIDTH-1:0]     INST_BYTES = 4;
    localparam logic [REG_ADDR_WIDTH-1:0] LINK_REG   = 1;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_NOR,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULH,
        ALU_NONE
    } la32_alu_op_e;

    // major opcodes, matched against the top bits of the word
    localparam logic [9:0] MAJ_3R   = 10'b0000000000;
    localparam logic [9:0] MAJ_UI5  = 10'b0000000001;
    localparam logic [6:0] MAJ_SI12 = 7'b0000001;
    localparam logic [3:0] MAJ_SI20 = 4'b0001;
    localparam logic [1:0] MAJ_BJ   = 2'b01;
    // ld.w lives at inst[31:22], not executed here
    localparam logic [9:0] MAJ_LD_W = 10'b0010100010;

    // 3R and UI5 minor codes in inst[21:15]
    localparam logic [6:0] OP_ADD_W   = 7'b0100000;
    localparam logic [6:0] OP_SUB_W   = 7'b0100010;
    localparam logic [6:0] OP_SLT     = 7'b0100100;
    localparam logic [6:0] OP_SLTU    = 7'b0100101;
    localparam logic [6:0] OP_NOR     = 7'b0101000;
    localparam logic [6:0] OP_AND     = 7'b0101001;
    localparam logic [6:0] OP_OR      = 7'b0101010;
    localparam logic [6:0] OP_XOR     = 7'b0101011;
    localparam logic [6:0] OP_SLL_W   = 7'b0101110;
    localparam logic [6:0] OP_SRL_W   = 7'b0101111;
    localparam logic [6:0] OP_SRA_W   = 7'b0110000;
    localparam logic [6:0] OP_MUL_W   = 7'b0111000;
    localparam logic [6:0] OP_MULH_W  = 7'b0111001;
    localparam logic [6:0] OP_MULH_WU = 7'b0111010;
    localparam logic [6:0] OP_DIV_W   = 7'b1000000;
    localparam logic [6:0] OP_SLLI_W  = 7'b0000001;
    localparam logic [6:0] OP_SRLI_W  = 7'b0001001;
    localparam logic [6:0] OP_SRAI_W  = 7'b0010001;

    // si12 minor codes in inst[24:22]
    localparam logic [2:0] OP_SLTI   = 3'b000;
    localparam logic [2:0] OP_SLTUI  = 3'b001;
    localparam logic [2:0] OP_ADDI_W = 3'b010;
    localparam logic [2:0] OP_ANDI   = 3'b101;
    localparam logic [2:0] OP_ORI    = 3'b110;
    localparam logic [2:0] OP_XORI   = 3'b111;

    // si20 minor codes in inst[27:25]
    localparam logic [2:0] OP_LU12I_W   = 3'b010;
    localparam logic [2:0] OP_PCADDU12I = 3'b110;

    // branch and jump minor codes in inst[29:26]
    localparam logic [3:0] OP_JIRL = 4'b0011;
    localparam logic [3:0] OP_B    = 4'b0100;
    localparam logic [3:0] OP_BL   = 4'b0101;
    localparam logic [3:0] OP_BEQ  = 4'b0110;
    localparam logic [3:0] OP_BNE  = 4'b0111;
    localparam logic [3:0] OP_BLT  = 4'b1000;
    localparam logic [3:0] OP_BGE  = 4'b1001;
    localparam logic [3:0] OP_BLTU = 4'b1010;
    localparam logic [3:0] OP_BGEU = 4'b1011;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     pc;
        la32_alu_op_e              op;
        logic                      is_unsigned;
        logic [DATA_WIDTH-1:0]     operand1;
        logic [DATA_WIDTH-1:0]     operand2;
        logic                      rw_en;
        logic [REG_ADDR_WIDTH-1:0] rw_addr;
        logic                      taken;
        logic [DATA_WIDTH-1:0]     target;
        logic                      illegal;
    } la32_id_info_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     pc;
        logic [DATA_WIDTH-1:0]     alu_result;
        logic                      rw_en;
        logic [REG_ADDR_WIDTH-1:0] rw_addr;
        logic                      taken;
        logic [DATA_WIDTH-1:0]     target;
        logic                      illegal;
    } la32_ex_info_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     next_pc;
        logic                      rw_en;
        logic [REG_ADDR_WIDTH-1:0] rw_addr;
        logic [DATA_WIDTH-1:0]     rw_data;
        logic                      illegal;
    } la32_result_t;

endpackage

// File: la32_regfile.sv
`timescale 1ns/1ps

module la32_regfile (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [la32_pkg::REG_ADDR_WIDTH-1:0] rd1_addr,
    input  logic [la32_pkg::REG_ADDR_WIDTH-1:0] rd2_addr,
    output logic [la32_pkg::DATA_WIDTH-1:0]     rd1_data,
    output logic [la32_pkg::DATA_WIDTH-1:0]     rd2_data,
    input  logic                                wr_en,
    input  logic [la32_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
    input  logic [la32_pkg::DATA_WIDTH-1:0]     wr_data
);

    logic [la32_pkg::DATA_WIDTH-1:0] regs [2**la32_pkg::REG_ADDR_WIDTH];

    // r0 is never written, so only 31 entries ever change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**la32_pkg::REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd1_data = (rd1_addr == '0) ? '0 : regs[rd1_addr];
    assign rd2_data = (rd2_addr == '0) ? '0 : regs[rd2_addr];

endmodule

// File: la32_decode.sv
`timescale 1ns/1ps

module la32_decode (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic [la32_pkg::DATA_WIDTH-1:0]     inst,
    input  logic [la32_pkg::DATA_WIDTH-1:0]     pc,
    output logic [la32_pkg::REG_ADDR_WIDTH-1:0] rd1_addr,
    output logic [la32_pkg::REG_ADDR_WIDTH-1:0] rd2_addr,
    input  logic [la32_pkg::DATA_WIDTH-1:0]     rd1_data,
    input  logic [la32_pkg::DATA_WIDTH-1:0]     rd2_data,
    output logic                                id_valid,
    output la32_pkg::la32_id_info_t             id_info
);

    localparam int DW = la32_pkg::DATA_WIDTH;

    typedef enum logic {
        IDLE,
        BUSY
    } state_e;

    state_e                            state;
    logic   [la32_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic   [DW-1:0]                   si12_sext;
    logic   [DW-1:0]                   si12_zext;
    logic   [DW-1:0]                   si20_hi;
    logic   [DW-1:0]                   offs16_ext;
    logic   [DW-1:0]                   offs26_ext;
    logic                              is_3r;
    logic                              is_ui5;
    logic                              is_si12;
    logic                              is_si20;
    logic                              is_bj;
    logic                              cmp_eq;
    logic                              cmp_lt;
    logic                              cmp_ltu;
    la32_pkg::la32_id_info_t           dec;

    assign rd         = inst[4:0];
    assign si12_sext  = {{(DW-12){inst[21]}}, inst[21:10]};
    assign si12_zext  = {{(DW-12){1'b0}}, inst[21:10]};
    assign si20_hi    = {inst[24:5], 12'b0};
    assign offs16_ext = {{(DW-18){inst[25]}}, inst[25:10], 2'b00};
    // offs26 is split, high part in inst[9:0]
    assign offs26_ext = {{(DW-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign is_3r   = (inst[31:22] == la32_pkg::MAJ_3R);
    assign is_ui5  = (inst[31:22] == la32_pkg::MAJ_UI5);
    assign is_si12 = (inst[31:25] == la32_pkg::MAJ_SI12);
    assign is_si20 = (inst[31:28] == la32_pkg::MAJ_SI20);
    assign is_bj   = (inst[31:30] == la32_pkg::MAJ_BJ);

    // branches compare rj against rd
    assign rd1_addr = inst[9:5];
    assign rd2_addr = is_bj ? rd : inst[14:10];

    assign cmp_eq  = (rd1_data == rd2_data);
    assign cmp_lt  = ($signed(rd1_data) < $signed(rd2_data));
    assign cmp_ltu = (rd1_data < rd2_data);

    always_comb begin
        dec          = '0;
        dec.pc       = pc;
        dec.op       = la32_pkg::ALU_NONE;
        dec.rw_addr  = rd;
        dec.operand1 = rd1_data;
        if (is_3r || is_ui5) begin
            dec.rw_en    = 1'b1;
            dec.operand2 = is_ui5 ? {{(DW-5){1'b0}}, inst[14:10]} : rd2_data;
            case ({is_ui5, inst[21:15]})
                {1'b0, la32_pkg::OP_ADD_W}:   dec.op = la32_pkg::ALU_ADD;
                {1'b0, la32_pkg::OP_SUB_W}:   dec.op = la32_pkg::ALU_SUB;
                {1'b0, la32_pkg::OP_SLT}:     dec.op = la32_pkg::ALU_SLT;
                {1'b0, la32_pkg::OP_SLTU}: begin
                    dec.op          = la32_pkg::ALU_SLT;
                    dec.is_unsigned = 1'b1;
                end
                {1'b0, la32_pkg::OP_NOR}:     dec.op = la32_pkg::ALU_NOR;
                {1'b0, la32_pkg::OP_AND}:     dec.op = la32_pkg::ALU_AND;
                {1'b0, la32_pkg::OP_OR}:      dec.op = la32_pkg::ALU_OR;
                {1'b0, la32_pkg::OP_XOR}:     dec.op = la32_pkg::ALU_XOR;
                {1'b0, la32_pkg::OP_SLL_W}:   dec.op = la32_pkg::ALU_SLL;
                {1'b0, la32_pkg::OP_SRL_W}:   dec.op = la32_pkg::ALU_SRL;
                {1'b0, la32_pkg::OP_SRA_W}:   dec.op = la32_pkg::ALU_SRA;
                {1'b0, la32_pkg::OP_MUL_W}:   dec.op = la32_pkg::ALU_MUL;
                {1'b0, la32_pkg::OP_MULH_W}:  dec.op = la32_pkg::ALU_MULH;
                {1'b0, la32_pkg::OP_MULH_WU}: begin
                    dec.op          = la32_pkg::ALU_MULH;
                    dec.is_unsigned = 1'b1;
                end
                {1'b1, la32_pkg::OP_SLLI_W}:  dec.op = la32_pkg::ALU_SLL;
                {1'b1, la32_pkg::OP_SRLI_W}:  dec.op = la32_pkg::ALU_SRL;
                {1'b1, la32_pkg::OP_SRAI_W}:  dec.op = la32_pkg::ALU_SRA;
                default:                      dec.op = la32_pkg::ALU_NONE;
            endcase
        end else if (is_si12) begin
            dec.rw_en    = 1'b1;
            dec.operand2 = si12_sext;
            case (inst[24:22])
                la32_pkg::OP_SLTI:   dec.op = la32_pkg::ALU_SLT;
                la32_pkg::OP_SLTUI: begin
                    dec.op          = la32_pkg::ALU_SLT;
                    dec.is_unsigned = 1'b1;
                end
                la32_pkg::OP_ADDI_W: dec.op = la32_pkg::ALU_ADD;
                la32_pkg::OP_ANDI: begin
                    dec.op       = la32_pkg::ALU_AND;
                    dec.operand2 = si12_zext;
                end
                la32_pkg::OP_ORI: begin
                    dec.op       = la32_pkg::ALU_OR;
                    dec.operand2 = si12_zext;
                end
                la32_pkg::OP_XORI: begin
                    dec.op       = la32_pkg::ALU_XOR;
                    dec.operand2 = si12_zext;
                end
                default:             dec.op = la32_pkg::ALU_NONE;
            endcase
        end else if (is_si20) begin
            dec.rw_en    = 1'b1;
            dec.operand1 = si20_hi;
            if (inst[27:25] == la32_pkg::OP_LU12I_W) begin
                dec.op = la32_pkg::ALU_ADD;
            end else if (inst[27:25] == la32_pkg::OP_PCADDU12I) begin
                dec.op       = la32_pkg::ALU_ADD;
                dec.operand2 = pc;
            end
        end else if (is_bj) begin
            // alu forms the link value pc + 4
            dec.op       = la32_pkg::ALU_ADD;
            dec.operand1 = pc;
            dec.operand2 = la32_pkg::INST_BYTES;
            dec.target   = pc + offs16_ext;
            case (inst[29:26])
                la32_pkg::OP_BEQ:  dec.taken = cmp_eq;
                la32_pkg::OP_BNE:  dec.taken = !cmp_eq;
                la32_pkg::OP_BLT:  dec.taken = cmp_lt;
                la32_pkg::OP_BGE:  dec.taken = !cmp_lt;
                la32_pkg::OP_BLTU: dec.taken = cmp_ltu;
                la32_pkg::OP_BGEU: dec.taken = !cmp_ltu;
                la32_pkg::OP_B: begin
                    dec.taken  = 1'b1;
                    dec.target = pc + offs26_ext;
                end
                la32_pkg::OP_BL: begin
                    dec.taken   = 1'b1;
                    dec.target  = pc + offs26_ext;
                    dec.rw_en   = 1'b1;
                    dec.rw_addr = la32_pkg::LINK_REG;
                end
                la32_pkg::OP_JIRL: begin
                    dec.taken  = 1'b1;
                    dec.target = rd1_data + offs16_ext;
                    dec.rw_en  = 1'b1;
                end
                default:           dec.op = la32_pkg::ALU_NONE;
            endcase
        end
        // anything left without an operation is illegal
        if (dec.op == la32_pkg::ALU_NONE) begin
            dec.illegal = 1'b1;
            dec.rw_en   = 1'b0;
            dec.taken   = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            id_valid <= 1'b0;
        end else begin
            id_valid <= 1'b0;
            if (state == IDLE && req) begin
                state    <= BUSY;
                id_valid <= 1'b1;
            end else if (state == BUSY && !req) begin
                state <= IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            id_info <= dec;
        end
    end

    // one accept per handshake
    a_single_issue: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid |=> !id_valid);

endmodule

// File: la32_execute.sv
`timescale 1ns/1ps

module la32_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    id_valid,
    input  la32_pkg::la32_id_info_t id_info,
    output logic                    ex_valid,
    output la32_pkg::la32_ex_info_t ex_info
);

    localparam int DW = la32_pkg::DATA_WIDTH;

    logic [DW-1:0]   a;
    logic [DW-1:0]   b;
    logic [DW-1:0]   alu_out;
    logic [2*DW-1:0] prod_s;
    logic [2*DW-1:0] prod_u;
    logic            lt;

    assign a = id_info.operand1;
    assign b = id_info.operand2;

    assign prod_s = $signed({{DW{a[DW-1]}}, a}) * $signed({{DW{b[DW-1]}}, b});
    assign prod_u = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
    assign lt     = id_info.is_unsigned ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (id_info.op)
            la32_pkg::ALU_ADD:  alu_out = a + b;
            la32_pkg::ALU_SUB:  alu_out = a - b;
            la32_pkg::ALU_SLT:  alu_out = {{(DW-1){1'b0}}, lt};
            la32_pkg::ALU_NOR:  alu_out = ~(a | b);
            la32_pkg::ALU_AND:  alu_out = a & b;
            la32_pkg::ALU_OR:   alu_out = a | b;
            la32_pkg::ALU_XOR:  alu_out = a ^ b;
            la32_pkg::ALU_SLL:  alu_out = a << b[4:0];
            la32_pkg::ALU_SRL:  alu_out = a >> b[4:0];
            la32_pkg::ALU_SRA:  alu_out = $signed(a) >>> b[4:0];
            la32_pkg::ALU_MUL:  alu_out = prod_s[DW-1:0];
            la32_pkg::ALU_MULH: alu_out = id_info.is_unsigned ? prod_u[2*DW-1:DW]
                                                              : prod_s[2*DW-1:DW];
            default:            alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_info.pc         <= id_info.pc;
            ex_info.alu_result <= alu_out;
            ex_info.rw_en      <= id_info.rw_en;
            ex_info.rw_addr    <= id_info.rw_addr;
            ex_info.taken      <= id_info.taken;
            ex_info.target     <= id_info.target;
            ex_info.illegal    <= id_info.illegal;
        end
    end

    // decode marks every unmapped encoding illegal
    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid && !id_info.illegal |-> id_info.op != la32_pkg::ALU_NONE);

endmodule

// File: la32_result.sv
`timescale 1ns/1ps

module la32_result (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req,
    input  logic                                ex_valid,
    input  la32_pkg::la32_ex_info_t             ex_info,
    output logic                                wr_en,
    output logic [la32_pkg::REG_ADDR_WIDTH-1:0] wr_addr,
    output logic [la32_pkg::DATA_WIDTH-1:0]     wr_data,
    output logic                                ack,
    output la32_pkg::la32_result_t              result
);

    logic [la32_pkg::DATA_WIDTH-1:0] next_pc;
    logic                            wr_ok;

    assign next_pc = ex_info.taken ? ex_info.target : ex_info.pc + la32_pkg::INST_BYTES;
    assign wr_ok   = ex_info.rw_en && !ex_info.illegal;

    // regfile captures this on the same edge that raises ack
    assign wr_en   = ex_valid && wr_ok;
    assign wr_addr = ex_info.rw_addr;
    assign wr_data = ex_info.alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack    <= 1'b0;
            result <= '0;
        end else begin
            if (ex_valid) begin
                ack            <= 1'b1;
                result.next_pc <= next_pc;
                result.rw_en   <= wr_ok;
                result.rw_addr <= wr_ok ? ex_info.rw_addr : '0;
                result.rw_data <= wr_ok ? ex_info.alu_result : '0;
                result.illegal <= ex_info.illegal;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    // ack only answers a request still held
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

endmodule

// File: la32_core.sv
`timescale 1ns/1ps

module la32_core (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req,
    input  logic [la32_pkg::DATA_WIDTH-1:0] inst,
    input  logic [la32_pkg::DATA_WIDTH-1:0] pc,
    output logic                            ack,
    output la32_pkg::la32_result_t          result
);

    logic [la32_pkg::REG_ADDR_WIDTH-1:0] rd1_addr;
    logic [la32_pkg::REG_ADDR_WIDTH-1:0] rd2_addr;
    logic [la32_pkg::DATA_WIDTH-1:0]     rd1_data;
    logic [la32_pkg::DATA_WIDTH-1:0]     rd2_data;
    logic                                wr_en;
    logic [la32_pkg::REG_ADDR_WIDTH-1:0] wr_addr;
    logic [la32_pkg::DATA_WIDTH-1:0]     wr_data;
    logic                                id_valid;
    la32_pkg::la32_id_info_t             id_info;
    logic                                ex_valid;
    la32_pkg::la32_ex_info_t             ex_info;

    la32_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .inst     (inst),
        .pc       (pc),
        .rd1_addr (rd1_addr),
        .rd2_addr (rd2_addr),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .id_valid (id_valid),
        .id_info  (id_info)
    );

    la32_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd1_addr (rd1_addr),
        .rd2_addr (rd2_addr),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    la32_execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_valid (id_valid),
        .id_info  (id_info),
        .ex_valid (ex_valid),
        .ex_info  (ex_info)
    );

    la32_result u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .ex_valid (ex_valid),
        .ex_info  (ex_info),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .ack      (ack),
        .result   (result)
    );

endmodule

// File: tb_la32_core.sv
`timescale 1ns/1ps

module tb_la32_core;

    localparam int DW = la32_pkg::DATA_WIDTH;
    localparam int AW = la32_pkg::REG_ADDR_WIDTH;

    typedef struct packed {
        logic [DW-1:0] inst;
        logic [DW-1:0] pc;
        logic          rw_en;
        logic [AW-1:0] rw_addr;
        logic [DW-1:0] rw_data;
        logic [DW-1:0] next_pc;
        logic          illegal;
    } vec_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req;
    logic [DW-1:0]          inst;
    logic [DW-1:0]          pc;
    logic                   ack;
    la32_pkg::la32_result_t result;

    vec_t          vectors[$];
    logic [DW-1:0] build_pc;
    logic [DW-1:0] link_pc;
    int            test_errors;
    int            pass_count;
    int            fail_count;

    la32_core u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .inst   (inst),
        .pc     (pc),
        .ack    (ack),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [DW-1:0] r3_word(input logic [6:0] minor,
            input logic [4:0] rk, input logic [4:0] rj, input logic [4:0] rd);
        return {la32_pkg::MAJ_3R, minor, rk, rj, rd};
    endfunction

    function automatic logic [DW-1:0] ui5_word(input logic [6:0] minor,
            input logic [4:0] ui5, input logic [4:0] rj, input logic [4:0] rd);
        return {la32_pkg::MAJ_UI5, minor, ui5, rj, rd};
    endfunction

    function automatic logic [DW-1:0] si12_word(input logic [2:0] minor,
            input logic [11:0] imm, input logic [4:0] rj, input logic [4:0] rd);
        return {la32_pkg::MAJ_SI12, minor, imm, rj, rd};
    endfunction

    function automatic logic [DW-1:0] si20_word(input logic [2:0] minor,
            input logic [19:0] imm, input logic [4:0] rd);
        return {la32_pkg::MAJ_SI20, minor, imm, rd};
    endfunction

    function automatic logic [DW-1:0] branch_word(input logic [3:0] minor,
            input logic [15:0] offs, input logic [4:0] rj, input logic [4:0] rd);
        return {la32_pkg::MAJ_BJ, minor, offs, rj, rd};
    endfunction

    // offs26 high bits sit in the low ten bits of the word
    function automatic logic [DW-1:0] jump26_word(input logic [3:0] minor,
            input logic [25:0] offs);
        return {la32_pkg::MAJ_BJ, minor, offs[15:0], offs[25:16]};
    endfunction

    task automatic store_vector(input logic [DW-1:0] word, input logic en,
            input logic [AW-1:0] addr, input logic [DW-1:0] data,
            input logic [DW-1:0] npc, input logic bad);
        vec_t v;
        v = '{word, build_pc, en, addr, data, npc, bad};
        vectors.push_back(v);
        build_pc = build_pc + 32'd4;
    endtask

    task automatic straight(input logic [DW-1:0] word, input logic en,
            input logic [AW-1:0] addr, input logic [DW-1:0] data);
        store_vector(word, en, addr, data, build_pc + 32'd4, 1'b0);
    endtask

    task automatic redirect(input logic [DW-1:0] word, input logic en,
            input logic [AW-1:0] addr, input logic [DW-1:0] data, input logic [DW-1:0] npc);
        store_vector(word, en, addr, data, npc, 1'b0);
    endtask

    task automatic rejected(input logic [DW-1:0] word);
        store_vector(word, 1'b0, 5'd0, 32'd0, build_pc + 32'd4, 1'b1);
    endtask

    task automatic build_vectors();
        build_pc = 32'h1c00_0000;
        // immediates, r1 = -1, r3 = 0x12345678, r6 = 5
        straight(si12_word(la32_pkg::OP_ADDI_W, 12'hfff, 5'd0, 5'd1), 1'b1, 5'd1, 32'hffff_ffff);
        straight(si12_word(la32_pkg::OP_ORI, 12'h800, 5'd0, 5'd2), 1'b1, 5'd2, 32'h0000_0800);
        straight(si20_word(la32_pkg::OP_LU12I_W, 20'h12345, 5'd3), 1'b1, 5'd3, 32'h1234_5000);
        straight(si12_word(la32_pkg::OP_ORI, 12'h678, 5'd3, 5'd3), 1'b1, 5'd3, 32'h1234_5678);
        straight(si12_word(la32_pkg::OP_ANDI, 12'hf0f, 5'd1, 5'd4), 1'b1, 5'd4, 32'h0000_0f0f);
        straight(si20_word(la32_pkg::OP_PCADDU12I, 20'h00001, 5'd5), 1'b1, 5'd5,
                 build_pc + 32'h1000);
        straight(si12_word(la32_pkg::OP_ADDI_W, 12'h005, 5'd0, 5'd6), 1'b1, 5'd6, 32'h5);
        // register alu and shifts
        straight(r3_word(la32_pkg::OP_ADD_W, 5'd6, 5'd3, 5'd7), 1'b1, 5'd7, 32'h1234_567d);
        straight(r3_word(la32_pkg::OP_SUB_W, 5'd3, 5'd6, 5'd8), 1'b1, 5'd8, 32'hedcb_a98d);
        straight(r3_word(la32_pkg::OP_NOR, 5'd2, 5'd3, 5'd9), 1'b1, 5'd9, 32'hedcb_a187);
        straight(r3_word(la32_pkg::OP_XOR, 5'd1, 5'd3, 5'd10), 1'b1, 5'd10, 32'hedcb_a987);
        straight(r3_word(la32_pkg::OP_SLT, 5'd6, 5'd1, 5'd11), 1'b1, 5'd11, 32'h1);
        straight(r3_word(la32_pkg::OP_SLTU, 5'd6, 5'd1, 5'd12), 1'b1, 5'd12, 32'h0);
        straight(ui5_word(la32_pkg::OP_SLLI_W, 5'd4, 5'd3, 5'd13), 1'b1, 5'd13, 32'h2345_6780);
        straight(ui5_word(la32_pkg::OP_SRLI_W, 5'd28, 5'd1, 5'd14), 1'b1, 5'd14, 32'hf);
        straight(ui5_word(la32_pkg::OP_SRAI_W, 5'd8, 5'd10, 5'd15), 1'b1, 5'd15, 32'hffed_cba9);
        straight(r3_word(la32_pkg::OP_SLL_W, 5'd6, 5'd6, 5'd16), 1'b1, 5'd16, 32'h0000_00a0);
        straight(r3_word(la32_pkg::OP_SRL_W, 5'd6, 5'd1, 5'd17), 1'b1, 5'd17, 32'h07ff_ffff);
        straight(r3_word(la32_pkg::OP_SRA_W, 5'd6, 5'd8, 5'd18), 1'b1, 5'd18, 32'hff6e_5d4c);
        // multiplies on -1 times -1
        straight(r3_word(la32_pkg::OP_MUL_W, 5'd1, 5'd1, 5'd19), 1'b1, 5'd19, 32'h1);
        straight(r3_word(la32_pkg::OP_MULH_W, 5'd1, 5'd1, 5'd20), 1'b1, 5'd20, 32'h0);
        straight(r3_word(la32_pkg::OP_MULH_WU, 5'd1, 5'd1, 5'd21), 1'b1, 5'd21, 32'hffff_fffe);
        // branches, taken then not taken
        redirect(branch_word(la32_pkg::OP_BEQ, 16'h0010, 5'd6, 5'd6), 1'b0, 5'd0, 32'h0,
                 build_pc + 32'h40);
        straight(branch_word(la32_pkg::OP_BEQ, 16'h0010, 5'd6, 5'd1), 1'b0, 5'd0, 32'h0);
        redirect(branch_word(la32_pkg::OP_BNE, 16'h0010, 5'd6, 5'd1), 1'b0, 5'd0, 32'h0,
                 build_pc + 32'h40);
        straight(branch_word(la32_pkg::OP_BNE, 16'h0010, 5'd6, 5'd6), 1'b0, 5'd0, 32'h0);
        redirect(branch_word(la32_pkg::OP_BLT, 16'hfffc, 5'd1, 5'd6), 1'b0, 5'd0, 32'h0,
                 build_pc - 32'h10);
        straight(branch_word(la32_pkg::OP_BLT, 16'h0010, 5'd6, 5'd1), 1'b0, 5'd0, 32'h0);
        redirect(branch_word(la32_pkg::OP_BGE, 16'h0010, 5'd6, 5'd1), 1'b0, 5'd0, 32'h0,
                 build_pc + 32'h40);
        straight(branch_word(la32_pkg::OP_BGE, 16'h0010, 5'd1, 5'd6), 1'b0, 5'd0, 32'h0);
        redirect(branch_word(la32_pkg::OP_BLTU, 16'h0010, 5'd6, 5'd1), 1'b0, 5'd0, 32'h0,
                 build_pc + 32'h40);
        straight(branch_word(la32_pkg::OP_BLTU, 16'h0010, 5'd1, 5'd6), 1'b0, 5'd0, 32'h0);
        redirect(branch_word(la32_pkg::OP_BGEU, 16'h0010, 5'd1, 5'd6), 1'b0, 5'd0, 32'h0,
                 build_pc + 32'h40);
        straight(branch_word(la32_pkg::OP_BGEU, 16'h0010, 5'd6, 5'd1), 1'b0, 5'd0, 32'h0);
        // jumps, bl links into r1 and jirl goes through r3, far from its own pc
        redirect(jump26_word(la32_pkg::OP_B, 26'h0000100), 1'b0, 5'd0, 32'h0,
                 build_pc + 32'h400);
        link_pc = build_pc + 32'd4;
        redirect(jump26_word(la32_pkg::OP_BL, 26'h0000020), 1'b1, 5'd1, link_pc,
                 build_pc + 32'h80);
        redirect(branch_word(la32_pkg::OP_JIRL, 16'h0004, 5'd3, 5'd22), 1'b1, 5'd22,
                 build_pc + 32'd4, 32'h1234_5688);
        // r0 write, then illegal words aimed at r6
        straight(si12_word(la32_pkg::OP_ADDI_W, 12'h123, 5'd0, 5'd0), 1'b1, 5'd0, 32'h123);
        rejected({la32_pkg::MAJ_LD_W, 12'h000, 5'd1, 5'd6});
        rejected(r3_word(la32_pkg::OP_DIV_W, 5'd1, 5'd3, 5'd6));
        rejected(32'hffff_ffff);
        straight(r3_word(la32_pkg::OP_ADD_W, 5'd6, 5'd0, 5'd23), 1'b1, 5'd23, 32'h5);
    endtask

    task automatic compare_field(input string name, input logic [DW-1:0] expected,
            input logic [DW-1:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h got %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string label);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: pass", label);
        end else begin
            fail_count++;
            $display("test %s: fail with %0d errors", label, test_errors);
        end
    endtask

    task automatic run_vector(input int idx);
        vec_t v;
        int   gap;
        int   n;
        v = vectors[idx];
        test_errors = 0;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        req  = 1'b1;
        inst = v.inst;
        pc   = v.pc;
        n = 0;
        while (!ack && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ack) begin
            $display("test %0d: ack never rose within 10 cycles of req", idx);
            test_errors++;
        end
        compare_field("ack latency", DW'(3), DW'(n));
        compare_field("result.next_pc", v.next_pc, result.next_pc);
        compare_field("result.rw_en", DW'(v.rw_en), DW'(result.rw_en));
        compare_field("result.rw_addr", DW'(v.rw_addr), DW'(result.rw_addr));
        compare_field("result.rw_data", v.rw_data, result.rw_data);
        compare_field("result.illegal", DW'(v.illegal), DW'(result.illegal));
        req = 1'b0;
        @(posedge clk);
        #1;
        compare_field("ack", DW'(0), DW'(ack));
        finish_test($sformatf("%0d pc %h inst %h", idx, v.pc, v.inst));
    endtask

    initial begin
        rst_n       = 1'b0;
        req         = 1'b0;
        inst        = '0;
        pc          = '0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        void'($urandom(32'hb7806d3d));
        build_vectors();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        compare_field("ack", DW'(0), DW'(ack));
        if (result !== '0) begin
            $display("CHECK FAILED result expected %h got %h", 71'h0, result);
            test_errors++;
        end
        finish_test("reset");
        for (int i = 0; i < vectors.size(); i++) begin
            run_vector(i);
        end
        $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // worst case per test is well under 12 cycles
    initial begin
        int limit;
        int cycle_count;
        #1;
        limit = vectors.size() * 12 + 20;
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run went past %0d clock cycles without finishing", limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
la32_pkg.sv
la32_regfile.sv
la32_decode.sv
la32_execute.sv
la32_result.sv
la32_core.sv
tb_la32_core.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_la32_core -f vlog.f -o tb_sim &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
